//--- Makefile
# Verilator flow for the instruction cache
#   make lint   lint the RTL top level and the testbench
#   make sim    build and run the testbench, exit status is the result
#   make clean  remove build output

OBJ_DIR := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing \
		rtl/icache_pkg.sv rtl/icache_way.sv rtl/icache_hit_merge.sv \
		rtl/icache_ctrl.sv rtl/icache_top.sv \
		--top-module icache_top
	verilator --lint-only --timing --assert -f icache_top.f \
		--top-module icache_top_tb

sim:
	verilator --binary --timing --assert -f icache_top.f \
		--top-module icache_top_tb \
		--Mdir $(OBJ_DIR) -o icache_top_sim
	./$(OBJ_DIR)/icache_top_sim

clean:
	rm -rf $(OBJ_DIR)

//--- bench/icache_top_sva.sv
/*
 * icache port assertions
 * result pulse width, request address hold, result and request apart
 */
`timescale 1ns/1ps
`default_nettype none

module icache_top_sva (
    input wire                          clk,
    input wire                          rst,
    input wire                          i_inst_valid,
    input wire                          i_mem_req,
    input wire [icache_pkg::ADDR_W-1:0] i_mem_addr
);

    // result is a single-cycle pulse
    a_inst_pulse: assert property (@(posedge clk) disable iff (!rst)
        i_inst_valid |=> !i_inst_valid)
        else $error("o_inst_valid high for more than one cycle");

    // request address held until the acknowledge
    a_req_addr_stable: assert property (@(posedge clk) disable iff (!rst)
        i_mem_req |=> (!i_mem_req || $stable(i_mem_addr)))
        else $error("o_mem_addr changed while o_mem_req was high");

    a_valid_req_apart: assert property (@(posedge clk) disable iff (!rst)
        !(i_inst_valid && i_mem_req))
        else $error("o_inst_valid and o_mem_req high together");

endmodule

bind icache_top icache_top_sva u_sva (
    .clk          (clk),
    .rst          (rst),
    .i_inst_valid (o_inst_valid),
    .i_mem_req    (o_mem_req),
    .i_mem_addr   (o_mem_addr)
);

`default_nettype wire

//--- bench/icache_top_tb.sv
/*
 * icache testbench
 * table of fetches against a reference cache model and a slow memory model
 */
`timescale 1ns/1ps
`default_nettype none

module icache_top_tb;

    localparam int ADDR_W    = icache_pkg::ADDR_W;
    localparam int LINE_W    = icache_pkg::LINE_W;
    localparam int INST_W    = icache_pkg::INST_W;
    localparam int OFFSET_W  = icache_pkg::OFFSET_W;
    localparam int AGE_W     = icache_pkg::AGE_W;
    localparam int N_WAYS    = 2;
    localparam int INDEX_W   = 6;
    localparam int SETS      = 1 << INDEX_W;
    localparam int TAG_W     = ADDR_W - INDEX_W - OFFSET_W;
    localparam logic [AGE_W-1:0] AGE_TOP = 3'd7;

    localparam int N_ENTRIES   = 19;
    // capture, lookup, up to 9 request cycles, fill, lookup, result
    localparam int MISS_MAX    = 16;
    localparam int CYCLE_LIMIT = N_ENTRIES * (MISS_MAX + 4) + 16;

    // expected miss, fetch address
    localparam logic [ADDR_W:0] STIM [N_ENTRIES] = '{
        {1'b1, 64'h0000_0000_0000_1000},  // cold miss in set 0
        {1'b0, 64'h0000_0000_0000_1000},  // same line hits
        {1'b0, 64'h0000_0000_0000_1004},  // hi half of that line
        {1'b1, 64'h0000_0000_0000_1008},  // set 1
        {1'b1, 64'h0000_0000_0000_0228},  // set 5, tag 1 into way 0
        {1'b1, 64'h0000_0000_0000_0428},  // tag 2 into way 1
        {1'b0, 64'h0000_0000_0000_022c},  // tag 1 hits, tag 2 older
        {1'b1, 64'h0000_0000_0000_0628},  // tag 3 evicts tag 2
        {1'b0, 64'h0000_0000_0000_0228},  // kept tag 1 hits
        {1'b1, 64'h0000_0000_0000_042c},  // evicted tag 2 misses
        {1'b1, 64'h0000_0000_0000_0628},  // tag 3 was replaced by tag 2
        {1'b0, 64'h0000_0000_0000_0428},
        {1'b1, 64'h0000_0000_0000_022c},
        {1'b1, 64'h1234_5678_9abc_def0},  // set 30, wide tag
        {1'b0, 64'h1234_5678_9abc_def4},
        {1'b1, 64'hffff_ffff_ffff_fff8},  // last set
        {1'b1, 64'h0000_0000_0000_0004},  // set 0, second way
        {1'b0, 64'h0000_0000_0000_1000},
        {1'b0, 64'h0000_0000_0000_0000}
    };

    logic                clk;
    logic                rst;
    logic                i_fetch;
    logic [ADDR_W-1:0]   i_addr;
    logic                i_mem_ack;
    logic [LINE_W-1:0]   i_mem_data;
    wire                 o_busy;
    wire  [INST_W-1:0]   o_inst;
    wire                 o_inst_valid;
    wire                 o_mem_req;
    wire  [ADDR_W-1:0]   o_mem_addr;

    logic [15:0]         lfsr_q = 16'd27;
    logic [ADDR_W-1:0]   last_req_addr;
    int                  cycle_count = 0;

    // reference cache state
    logic                ref_valid [N_WAYS][SETS];
    logic [TAG_W-1:0]    ref_tag   [N_WAYS][SETS];
    logic [AGE_W-1:0]    ref_age   [N_WAYS][SETS];

    icache_top i_icache_top (
        .clk          (clk),
        .rst          (rst),
        .i_fetch      (i_fetch),
        .i_addr       (i_addr),
        .i_mem_ack    (i_mem_ack),
        .i_mem_data   (i_mem_data),
        .o_busy       (o_busy),
        .o_inst       (o_inst),
        .o_inst_valid (o_inst_valid),
        .o_mem_req    (o_mem_req),
        .o_mem_addr   (o_mem_addr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Simulation failed");
            $fatal(1, "timeout, no result after %0d cycles", cycle_count);
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[6:0], lfsr_q[0]};
        end
    endtask

    // upper word address bits 33..2 in the hi half, inverted in the lo half
    function automatic logic [LINE_W-1:0] mem_word(input logic [ADDR_W-1:0] line_addr);
        logic [ADDR_W-1:0] upper;
        upper = line_addr | 64'd4;
        mem_word = {upper[33:2], ~upper[33:2]};
    endfunction

    function automatic logic [INST_W-1:0] expected_inst(input logic [ADDR_W-1:0] addr);
        logic [LINE_W-1:0] word;
        word = mem_word({addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}});
        expected_inst = addr[2] ? word[63:32] : word[31:0];
    endfunction

    // touched way to 0, the rest age by one up to 7
    task automatic ref_touch(input int set_idx, input int way);
        for (int w = 0; w < N_WAYS; w++) begin
            if (w == way) begin
                ref_age[w][set_idx] = '0;
            end else if (ref_age[w][set_idx] != AGE_TOP) begin
                ref_age[w][set_idx] = ref_age[w][set_idx] + 3'd1;
            end
        end
    endtask

    task automatic ref_access(input logic [ADDR_W-1:0] addr, output logic miss);
        int               set_idx;
        int               hit_way;
        int               victim;
        logic [TAG_W-1:0] tag;
        set_idx = int'(addr[OFFSET_W +: INDEX_W]);
        tag     = addr[ADDR_W-1 -: TAG_W];
        hit_way = -1;
        for (int w = 0; w < N_WAYS; w++) begin
            if (ref_valid[w][set_idx] && ref_tag[w][set_idx] == tag) begin
                hit_way = w;
            end
        end
        miss = (hit_way < 0);
        if (miss) begin
            victim = -1;
            for (int w = 0; w < N_WAYS; w++) begin
                if (!ref_valid[w][set_idx] && victim < 0) begin
                    victim = w;
                end
            end
            if (victim < 0) begin
                victim = 0;
                for (int w = 1; w < N_WAYS; w++) begin
                    if (ref_age[w][set_idx] > ref_age[victim][set_idx]) begin
                        victim = w;
                    end
                end
            end
            ref_valid[victim][set_idx] = 1'b1;
            ref_tag[victim][set_idx]   = tag;
            // fill, then the repeated lookup hits
            ref_touch(set_idx, victim);
            hit_way = victim;
        end
        ref_touch(set_idx, hit_way);
    endtask

    // lat counts falling edges after the capturing edge
    task automatic run_fetch(input logic [ADDR_W-1:0] addr, output int lat,
                             output logic saw_req);
        logic done;
        @(posedge clk);
        i_fetch <= 1'b1;
        i_addr  <= addr;
        @(posedge clk);
        i_fetch <= 1'b0;
        lat     = 0;
        saw_req = 1'b0;
        done    = 1'b0;
        while (!done) begin
            @(negedge clk);
            lat++;
            if (o_mem_req) begin
                saw_req = 1'b1;
            end
            if (o_inst_valid) begin
                done = 1'b1;
                check_value("o_busy", 64'(o_busy), 64'd0);
            end else begin
                check_value("o_busy", 64'(o_busy), 64'd1);
            end
        end
    endtask

    initial begin : memory_model
        logic [7:0]        delay;
        logic [ADDR_W-1:0] req_addr;
        i_mem_ack  = 1'b0;
        i_mem_data = '0;
        forever begin
            @(negedge clk);
            if (o_mem_req) begin
                req_addr      = o_mem_addr;
                last_req_addr = req_addr;
                check_value("o_mem_addr[2:0]", 64'(o_mem_addr[2:0]), 64'd0);
                random_bits(3, delay);
                repeat (delay) begin
                    @(negedge clk);
                    check_value("o_mem_req", 64'(o_mem_req), 64'd1);
                    check_value("o_mem_addr", o_mem_addr, req_addr);
                end
                @(posedge clk);
                i_mem_ack  <= 1'b1;
                i_mem_data <= mem_word(req_addr);
                @(posedge clk);
                i_mem_ack  <= 1'b0;
            end
        end
    end

    initial begin : stimulus
        logic              model_miss;
        logic              saw_req;
        int                lat;
        logic [ADDR_W-1:0] addr;
        i_fetch       = 1'b0;
        i_addr        = '0;
        rst           = 1'b0;
        last_req_addr = '1;
        for (int w = 0; w < N_WAYS; w++) begin
            for (int s = 0; s < SETS; s++) begin
                ref_valid[w][s] = 1'b0;
                ref_age[w][s]   = '0;
            end
        end
        repeat (3) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        check_value("o_busy", 64'(o_busy), 64'd0);
        check_value("o_mem_req", 64'(o_mem_req), 64'd0);
        check_value("o_inst_valid", 64'(o_inst_valid), 64'd0);

        for (int e = 0; e < N_ENTRIES; e++) begin
            addr = STIM[e][ADDR_W-1:0];
            ref_access(addr, model_miss);
            check_value("table miss flag", 64'(STIM[e][ADDR_W]), 64'(model_miss));
            last_req_addr = '1;
            run_fetch(addr, lat, saw_req);
            check_value("o_mem_req seen", 64'(saw_req), 64'(model_miss));
            if (model_miss) begin
                check_value("o_mem_addr", last_req_addr,
                            {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}});
            end else begin
                check_value("hit latency", 64'(lat), 64'd2);
            end
            check_value("o_inst", 64'(o_inst), 64'(expected_inst(addr)));
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- icache_top.f
rtl/icache_pkg.sv
rtl/icache_way.sv
rtl/icache_hit_merge.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
bench/icache_top_sva.sv
bench/icache_top_tb.sv

//--- rtl/icache_ctrl.sv
/*
 * icache controller
 * fetch FSM, address capture, miss request, victim choice and fill
 */
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl #(
    parameter int N_WAYS  = 2,
    parameter int INDEX_W = 6
) (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire                                   i_fetch,
    input  wire  [icache_pkg::ADDR_W-1:0]         i_addr,
    input  wire                                   i_any_hit,
    input  wire  [N_WAYS-1:0]                     i_way_valid,
    input  wire  [N_WAYS*icache_pkg::AGE_W-1:0]   i_way_age,
    input  wire                                   i_mem_ack,
    input  wire  [icache_pkg::LINE_W-1:0]         i_mem_data,
    output logic                                  o_busy,
    output logic                                  o_lookup,
    output logic                                  o_deliver,
    output logic                                  o_half,
    output logic [INDEX_W-1:0]                    o_index,
    output logic [icache_pkg::ADDR_W-INDEX_W-icache_pkg::OFFSET_W-1:0] o_tag,
    output logic [N_WAYS-1:0]                     o_fill_way,
    output logic [icache_pkg::LINE_W-1:0]         o_fill_data,
    output logic                                  o_mem_req,
    output logic [icache_pkg::ADDR_W-1:0]         o_mem_addr
);

    localparam int OFFSET_W = icache_pkg::OFFSET_W;
    localparam int AGE_W    = icache_pkg::AGE_W;
    localparam int TAG_W    = icache_pkg::ADDR_W - INDEX_W - OFFSET_W;

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_LOOKUP = 2'd1;
    localparam logic [1:0] ST_REFILL = 2'd2;
    localparam logic [1:0] ST_FILL   = 2'd3;

    logic [1:0]             state_q;
    logic [1:0]             state_d;
    logic [TAG_W-1:0]       tag_q;
    logic [INDEX_W-1:0]     index_q;
    logic                   half_q;
    logic [N_WAYS-1:0]      victim;
    logic [N_WAYS-1:0]      victim_q;
    logic                   free_found;
    logic [AGE_W-1:0]       oldest_age;
    icache_pkg::line_word_t fill_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (i_fetch) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                state_d = i_any_hit ? ST_IDLE : ST_REFILL;
            end
            ST_REFILL: begin
                if (i_mem_ack) begin
                    state_d = ST_FILL;
                end
            end
            default: begin
                // fill written, look up again and hit
                state_d = ST_LOOKUP;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // fetch address held from strobe until delivery
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && i_fetch) begin
            tag_q   <= i_addr[icache_pkg::ADDR_W-1 -: TAG_W];
            index_q <= i_addr[OFFSET_W +: INDEX_W];
            half_q  <= i_addr[icache_pkg::HALF_BIT];
        end
    end

    // first invalid way, else oldest, ties to lowest index
    always_comb begin
        victim     = '0;
        free_found = 1'b0;
        oldest_age = i_way_age[0 +: AGE_W];
        for (int w = 0; w < N_WAYS; w++) begin
            if (!i_way_valid[w] && !free_found) begin
                victim[w]  = 1'b1;
                free_found = 1'b1;
            end
        end
        if (!free_found) begin
            victim[0] = 1'b1;
            for (int w = 1; w < N_WAYS; w++) begin
                if (i_way_age[w*AGE_W +: AGE_W] > oldest_age) begin
                    victim     = '0;
                    victim[w]  = 1'b1;
                    oldest_age = i_way_age[w*AGE_W +: AGE_W];
                end
            end
        end
    end

    // ages are frozen between the miss and the fill
    always_ff @(posedge clk) begin
        if (state_q == ST_LOOKUP && !i_any_hit) begin
            victim_q <= victim;
        end
        if (state_q == ST_REFILL && i_mem_ack) begin
            fill_q.raw <= i_mem_data;
        end
    end

    assign o_busy      = (state_q != ST_IDLE);
    assign o_lookup    = (state_q == ST_LOOKUP);
    assign o_deliver   = o_lookup & i_any_hit;
    assign o_half      = half_q;
    assign o_index     = index_q;
    assign o_tag       = tag_q;
    assign o_fill_way  = (state_q == ST_FILL) ? victim_q : '0;
    assign o_fill_data = fill_q.raw;
    assign o_mem_req   = (state_q == ST_REFILL);
    assign o_mem_addr  = {tag_q, index_q, {OFFSET_W{1'b0}}};

endmodule

`default_nettype wire

//--- rtl/icache_hit_merge.sv
/*
 * icache hit merge
 * one-hot way select, instruction half pick, registered result
 */
`timescale 1ns/1ps
`default_nettype none

module icache_hit_merge #(
    parameter int N_WAYS = 2
) (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire  [N_WAYS-1:0]                     i_hit,
    input  wire  [N_WAYS*icache_pkg::LINE_W-1:0]  i_data,
    input  wire                                   i_deliver,
    input  wire                                   i_half,
    output logic                                  o_any_hit,
    output logic [icache_pkg::INST_W-1:0]         o_inst,
    output logic                                  o_inst_valid
);

    localparam int LINE_W = icache_pkg::LINE_W;

    icache_pkg::line_word_t        merged;
    logic [icache_pkg::INST_W-1:0] inst_sel;

    // at most one way hits, so and-or is enough
    always_comb begin
        merged.raw = '0;
        for (int w = 0; w < N_WAYS; w++) begin
            merged.raw = merged.raw | (i_data[w*LINE_W +: LINE_W] & {LINE_W{i_hit[w]}});
        end
    end

    assign o_any_hit = |i_hit;
    assign inst_sel  = i_half ? merged.inst.hi : merged.inst.lo;

    always_ff @(posedge clk) begin
        if (i_deliver) begin
            o_inst <= inst_sel;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            o_inst_valid <= 1'b0;
        end else begin
            o_inst_valid <= i_deliver;
        end
    end

endmodule

`default_nettype wire

//--- rtl/icache_pkg.sv
/*
 * icache shared definitions
 * address and word widths, age counter limit, line word layout
 */
`default_nettype none

package icache_pkg;

    // fetch address and memory port
    localparam int ADDR_W = 64;
    localparam int LINE_W = 64;
    localparam int INST_W = 32;

    // byte offset below the set index
    localparam int OFFSET_W = 3;

    // address bit that picks hi or lo instruction of a line
    localparam int HALF_BIT = 2;

    // per-set replacement age
    localparam int AGE_W = 3;
    localparam logic [AGE_W-1:0] AGE_MAX = {AGE_W{1'b1}};

    // one cache line, written whole on refill and split on fetch
    typedef union packed {
        logic [LINE_W-1:0] raw;
        struct packed {
            logic [INST_W-1:0] hi;
            logic [INST_W-1:0] lo;
        } inst;
    } line_word_t;

endpackage

`default_nettype wire

//--- rtl/icache_top.sv
/*
 * icache top
 * set associative fetch cache over a 64-bit memory port
 */
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
    parameter int N_WAYS  = 2,
    parameter int INDEX_W = 6
) (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire                                   i_fetch,
    input  wire  [icache_pkg::ADDR_W-1:0]         i_addr,
    input  wire                                   i_mem_ack,
    input  wire  [icache_pkg::LINE_W-1:0]         i_mem_data,
    output logic                                  o_busy,
    output logic [icache_pkg::INST_W-1:0]         o_inst,
    output logic                                  o_inst_valid,
    output logic                                  o_mem_req,
    output logic [icache_pkg::ADDR_W-1:0]         o_mem_addr
);

    localparam int TAG_W  = icache_pkg::ADDR_W - INDEX_W - icache_pkg::OFFSET_W;
    localparam int AGE_W  = icache_pkg::AGE_W;
    localparam int LINE_W = icache_pkg::LINE_W;

    logic [INDEX_W-1:0]       index;
    logic [TAG_W-1:0]         tag;
    logic                     lookup;
    logic                     deliver;
    logic                     half;
    logic                     any_hit;
    logic                     set_touch;
    logic [N_WAYS-1:0]        fill_way;
    logic [LINE_W-1:0]        fill_data;
    logic [N_WAYS-1:0]        way_hit;
    logic [N_WAYS-1:0]        way_valid;
    logic [N_WAYS*AGE_W-1:0]  way_age;
    logic [N_WAYS*LINE_W-1:0] way_data;

    // ages move on a hit or on a fill of any way
    assign set_touch = any_hit | (|fill_way);

    icache_ctrl #(
        .N_WAYS  (N_WAYS),
        .INDEX_W (INDEX_W)
    ) u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .i_fetch     (i_fetch),
        .i_addr      (i_addr),
        .i_any_hit   (any_hit),
        .i_way_valid (way_valid),
        .i_way_age   (way_age),
        .i_mem_ack   (i_mem_ack),
        .i_mem_data  (i_mem_data),
        .o_busy      (o_busy),
        .o_lookup    (lookup),
        .o_deliver   (deliver),
        .o_half      (half),
        .o_index     (index),
        .o_tag       (tag),
        .o_fill_way  (fill_way),
        .o_fill_data (fill_data),
        .o_mem_req   (o_mem_req),
        .o_mem_addr  (o_mem_addr)
    );

    for (genvar g = 0; g < N_WAYS; g++) begin : g_way
        icache_way #(
            .INDEX_W (INDEX_W)
        ) u_way (
            .clk         (clk),
            .rst         (rst),
            .i_index     (index),
            .i_tag       (tag),
            .i_lookup    (lookup),
            .i_fill      (fill_way[g]),
            .i_fill_data (fill_data),
            .i_hit_any   (set_touch),
            .o_hit       (way_hit[g]),
            .o_valid     (way_valid[g]),
            .o_age       (way_age[g*AGE_W +: AGE_W]),
            .o_data      (way_data[g*LINE_W +: LINE_W])
        );
    end

    icache_hit_merge #(
        .N_WAYS (N_WAYS)
    ) u_merge (
        .clk          (clk),
        .rst          (rst),
        .i_hit        (way_hit),
        .i_data       (way_data),
        .i_deliver    (deliver),
        .i_half       (half),
        .o_any_hit    (any_hit),
        .o_inst       (o_inst),
        .o_inst_valid (o_inst_valid)
    );

endmodule

`default_nettype wire

//--- rtl/icache_way.sv
/*
 * icache way
 * tag, valid, data and age per set with tag compare
 */
`timescale 1ns/1ps
`default_nettype none

module icache_way #(
    parameter int INDEX_W = 6
) (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire  [INDEX_W-1:0]                    i_index,
    input  wire  [icache_pkg::ADDR_W-INDEX_W-icache_pkg::OFFSET_W-1:0] i_tag,
    input  wire                                   i_lookup,
    input  wire                                   i_fill,
    input  wire  [icache_pkg::LINE_W-1:0]         i_fill_data,
    input  wire                                   i_hit_any,
    output logic                                  o_hit,
    output logic                                  o_valid,
    output logic [icache_pkg::AGE_W-1:0]          o_age,
    output logic [icache_pkg::LINE_W-1:0]         o_data
);

    localparam int TAG_W = icache_pkg::ADDR_W - INDEX_W - icache_pkg::OFFSET_W;
    localparam int SETS  = 1 << INDEX_W;
    localparam int AGE_W = icache_pkg::AGE_W;

    logic [TAG_W-1:0]              tag_mem  [SETS];
    logic [icache_pkg::LINE_W-1:0] data_mem [SETS];
    logic [AGE_W-1:0]              age_q    [SETS];
    logic [SETS-1:0]               valid_q;
    logic [AGE_W-1:0]              age_next;

    // line payload
    always_ff @(posedge clk) begin
        if (i_fill) begin
            tag_mem[i_index]  <= i_tag;
            data_mem[i_index] <= i_fill_data;
        end
    end

    assign o_valid = valid_q[i_index];
    assign o_age   = age_q[i_index];
    assign o_data  = data_mem[i_index];
    assign o_hit   = i_lookup & o_valid & (tag_mem[i_index] == i_tag);

    // i_hit_any marks a set touched by a hit or by a fill in any way
    always_comb begin
        if (i_fill || o_hit) begin
            age_next = '0;
        end else if (o_age == icache_pkg::AGE_MAX) begin
            age_next = o_age;
        end else begin
            age_next = o_age + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= '0;
            for (int s = 0; s < SETS; s++) begin
                age_q[s] <= '0;
            end
        end else begin
            if (i_fill) begin
                valid_q[i_index] <= 1'b1;
            end
            // a missing lookup leaves the ages alone
            if (i_fill || i_hit_any) begin
                age_q[i_index] <= age_next;
            end
        end
    end

endmodule

`default_nettype wire
